/* vlog.f */
+incdir+source
source/fpAdderPkg.sv
source/fpUnpack.sv
source/fpAlign.sv
source/fpMantissaAdd.sv
source/fpNormalizeRound.sv
source/fpAdder.sv
verification/fpAdderTb.sv

/* verification/fpAdder_stim.txt */
# op (0 add, 1 sub), A, B, expected result, expected flags, all hex
# flags are {invalid, overflow, inexact}
0 3F800000 3F800000 40000000 0
0 3F800000 40000000 40400000 0
1 40400000 3F800000 40000000 0
0 3F800000 BF000000 3F000000 0
1 BF800000 3F800000 C0000000 0
0 3F800000 33800000 3F800000 1
0 3F800000 34400000 3F800002 1
0 3F800000 33C00000 3F800001 1
0 3F800000 3F7FFFFF 40000000 1
1 3F800000 3F800000 00000000 0
1 3F800001 3F800000 34000000 0
1 3F800000 3F800001 B4000000 0
0 00000001 00000001 00000002 0
0 00400000 00400000 00800000 0
1 00800001 00800000 00000001 0
0 7FC00000 3F800000 7FC00000 4
0 7F800001 3F800000 7FC00000 4
1 7F800000 7F800000 7FC00000 4
0 7F800000 3F800000 7F800000 0
0 3F800000 FF800000 FF800000 0
0 80000000 80000000 80000000 0
1 80000000 00000000 80000000 0
0 7F7FFFFF 7F7FFFFF 7F800000 3
0 FF7FFFFF FF7FFFFF FF800000 3

/* verification/fpAdderTb.sv */
//Testbench for the FP adder pipeline that replays stored vectors and checks responses in order
`timescale 1ns/1ps
`include "fpAdder_defines.svh"

module fpAdderTb;

    localparam int LATENCY       = 4;
    localparam int DRAIN_TIMEOUT = 20;

    logic                   clock;
    logic                   reset;
    fpAdderPkg::fpRequest_t request;
    fpAdderPkg::fpResult_t  response;

    //Expected results in issue order
    logic [`FP_WIDTH-1:0]   expectWords[$];
    fpAdderPkg::fpFlags_t   expectFlags[$];
    int                     issueCycles[$];
    int                     cycleCount = 0;
    logic [31:0]            lcgState;

    fpAdder fpAdder_i
    (
        .clock    (clock),
        .reset    (reset),
        .request  (request),
        .response (response)
    );

    initial
    begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    always @(posedge clock)
        cycleCount <= cycleCount + 1;

    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    task automatic abortRun();
        $display("TEST FAIL");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic checkWord(input string name, input logic [`FP_WIDTH-1:0] actual,
                             input logic [`FP_WIDTH-1:0] expected);
        if (actual !== expected)
        begin
            $display("Fail at %0t ns: %s got %h, expected %h", $time, name, actual, expected);
            abortRun();
        end
    endtask

    task automatic checkFlags(input string name, input fpAdderPkg::fpFlags_t actual,
                              input fpAdderPkg::fpFlags_t expected);
        if (actual !== expected)
        begin
            $display("Fail at %0t ns: %s got %b, expected %b", $time, name, actual, expected);
            abortRun();
        end
    endtask

    task automatic checkLatency(input string name, input int actual, input int expected);
        if (actual != expected)
        begin
            $display("Fail at %0t ns: %s got %0d, expected %0d", $time, name, actual, expected);
            abortRun();
        end
    endtask

    //Pops the oldest outstanding operation for each response
    task automatic checkResponse();
        logic [`FP_WIDTH-1:0] word;
        fpAdderPkg::fpFlags_t flags;
        int                   issued;
        if (expectWords.size() == 0)
        begin
            $display("Error at %0t ns: a response came with no operation outstanding", $time);
            abortRun();
        end
        else
        begin
            word   = expectWords.pop_front();
            flags  = expectFlags.pop_front();
            issued = issueCycles.pop_front();
            checkWord("response.result", response.result, word);
            checkFlags("response.flags", response.flags, flags);
            checkLatency("response latency", cycleCount - issued, LATENCY);
        end
    endtask

    //Outputs settle after the rising edge, so look at the falling edge
    initial
    begin
        forever
        begin
            @(negedge clock);
            if (!reset && response.valid === 1'b1)
                checkResponse();
        end
    end

    //One-cycle strobe then a random gap of 0 to 3 cycles
    task automatic issueVector(input logic [31:0] opField, input logic [31:0] aField,
                               input logic [31:0] bField, input logic [31:0] wordField,
                               input logic [31:0] flagField);
        int gap;
        request.valid = 1'b1;
        request.op    = fpAdderPkg::fpOp_e'(opField[0]);
        request.a     = aField;
        request.b     = bField;
        expectWords.push_back(wordField);
        expectFlags.push_back(fpAdderPkg::fpFlags_t'(flagField[2:0]));
        issueCycles.push_back(cycleCount);
        @(posedge clock);
        #1;
        request.valid = 1'b0;
        gap = int'(nextRandom() >> 30);
        repeat (gap)
        begin
            @(posedge clock);
            #1;
        end
    endtask

    initial
    begin
        int          fd;
        int          fieldCount;
        int          vectorCount;
        int          waited;
        string       line;
        logic [31:0] opField, aField, bField, wordField, flagField;
        reset       = 1'b1;
        request     = '0;
        lcgState    = 32'h5509e2d0;
        vectorCount = 0;
        repeat (10) @(posedge clock);
        #1;
        reset = 1'b0;
        fd = $fopen("verification/fpAdder_stim.txt", "r");
        if (fd == 0)
        begin
            $display("Error: the stimulus file verification/fpAdder_stim.txt cannot be opened");
            abortRun();
        end
        else
        begin
            while (!$feof(fd))
            begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line[0] != "#")
                begin
                    fieldCount = $sscanf(line, "%h %h %h %h %h",
                                         opField, aField, bField, wordField, flagField);
                    if (fieldCount != 5)
                    begin
                        $display("Error: a stimulus line has %0d fields instead of 5", fieldCount);
                        abortRun();
                    end
                    else
                    begin
                        issueVector(opField, aField, bField, wordField, flagField);
                        vectorCount++;
                    end
                end
            end
            $fclose(fd);
        end

        //Drain the pipeline
        waited = 0;
        while (expectWords.size() != 0 && waited < DRAIN_TIMEOUT)
        begin
            @(posedge clock);
            waited++;
        end
        if (vectorCount == 0)
            $display("Error: the stimulus file held no vectors");
        else if (expectWords.size() != 0)
            $display("Error: timed out with %0d responses missing", expectWords.size());
        if (vectorCount == 0 || expectWords.size() != 0)
            abortRun();
        else
        begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

/* source/fpAdder.sv */
//Four-stage pipelined single-precision adder and subtractor
`timescale 1ns/1ps

module fpAdder
(
    input  logic                   clock,
    input  logic                   reset,
    input  fpAdderPkg::fpRequest_t request,
    output fpAdderPkg::fpResult_t  response
);

    fpAdderPkg::fpUnpacked_t unpacked;
    fpAdderPkg::fpAligned_t  aligned;
    fpAdderPkg::fpSum_t      sum;

    fpUnpack unpack_i
    (
        .clock    (clock),
        .reset    (reset),
        .request  (request),
        .unpacked (unpacked)
    );

    fpAlign align_i
    (
        .clock    (clock),
        .reset    (reset),
        .unpacked (unpacked),
        .aligned  (aligned)
    );

    fpMantissaAdd mantissaAdd_i
    (
        .clock   (clock),
        .reset   (reset),
        .aligned (aligned),
        .sum     (sum)
    );

    fpNormalizeRound normalizeRound_i
    (
        .clock    (clock),
        .reset    (reset),
        .sum      (sum),
        .response (response)
    );

endmodule

/* source/fpNormalizeRound.sv */
//FP adder stage 4 that normalizes, rounds to nearest even and packs the result
`timescale 1ns/1ps
`include "fpAdder_defines.svh"

module fpNormalizeRound
(
    input  logic                  clock,
    input  logic                  reset,
    input  fpAdderPkg::fpSum_t    sum,
    output fpAdderPkg::fpResult_t response
);

    logic [4:0]               leadZeros;
    logic [`FP_EXP_WIDTH-1:0] shiftLimit, shiftAmt;
    logic [`FP_MAN_WIDTH+3:0] normMant;
    logic [`FP_EXP_WIDTH:0]   normExp, finalExp;
    logic                     roundUp;
    logic [`FP_MAN_WIDTH+1:0] rounded;
    logic [`FP_MAN_WIDTH-1:0] fraction;
    logic                     hidden, overflow, inexact;
    logic [`FP_WIDTH-1:0]     resultWord;
    fpAdderPkg::fpFlags_t     resultFlags;

    //Leading zeros below the carry bit
    function automatic logic [4:0] countLeadingZeros(input logic [`FP_MAN_WIDTH+3:0] value);
        logic [4:0] count;
        logic       found;
        count = 5'd0;
        found = 1'b0;
        for (int i = `FP_MAN_WIDTH + 3; i >= 0; i--)
        begin
            if (!found && !value[i])
                count = count + 5'd1;
            else
                found = 1'b1;
        end
        return count;
    endfunction

    assign leadZeros = countLeadingZeros(sum.sum[`FP_MAN_WIDTH+3:0]);

    //Left shift stops at exponent 1 and leaves a subnormal
    assign shiftLimit = sum.exponent - `FP_EXP_WIDTH'(1);
    assign shiftAmt   = ({{(`FP_EXP_WIDTH-5){1'b0}}, leadZeros} > shiftLimit)
                        ? shiftLimit : {{(`FP_EXP_WIDTH-5){1'b0}}, leadZeros};

    always_comb
    begin
        if (sum.sum[`FP_MAN_WIDTH+4])
        begin
            //Carry out shifts right and keeps sticky
            normMant = {sum.sum[`FP_MAN_WIDTH+4:2], |sum.sum[1:0]};
            normExp  = {1'b0, sum.exponent} + 9'd1;
        end
        else
        begin
            normMant = sum.sum[`FP_MAN_WIDTH+3:0] << shiftAmt;
            normExp  = {1'b0, sum.exponent} - {1'b0, shiftAmt};
        end
    end

    //Nearest even on guard, round and sticky
    assign roundUp  = normMant[2] & (normMant[1] | normMant[0] | normMant[3]);
    assign rounded  = {1'b0, normMant[`FP_MAN_WIDTH+3:3]}
                      + {{(`FP_MAN_WIDTH+1){1'b0}}, roundUp};
    assign finalExp = normExp + {{`FP_EXP_WIDTH{1'b0}}, rounded[`FP_MAN_WIDTH+1]};
    assign hidden   = rounded[`FP_MAN_WIDTH+1] | rounded[`FP_MAN_WIDTH];
    assign fraction = rounded[`FP_MAN_WIDTH+1] ? rounded[`FP_MAN_WIDTH:1]
                                               : rounded[`FP_MAN_WIDTH-1:0];
    assign inexact  = |normMant[2:0];
    assign overflow = hidden && (finalExp >= `FP_EXP_MAX);

    always_comb
    begin
        if (sum.special)
        begin
            resultWord  = sum.specialWord;
            resultFlags = sum.specialFlags;
        end
        else if (overflow)
        begin
            resultWord  = {sum.sign, {`FP_EXP_WIDTH{1'b1}}, {`FP_MAN_WIDTH{1'b0}}};
            resultFlags = '{invalid: 1'b0, overflow: 1'b1, inexact: 1'b1};
        end
        else
        begin
            //No hidden bit means a subnormal or zero with exponent field 0
            resultWord  = {sum.sign,
                           hidden ? finalExp[`FP_EXP_WIDTH-1:0] : {`FP_EXP_WIDTH{1'b0}},
                           fraction};
            resultFlags = '{invalid: 1'b0, overflow: 1'b0, inexact: inexact};
        end
    end

    always_ff @(posedge clock)
    begin
        if (reset)
            response.valid <= 1'b0;
        else
            response.valid <= sum.valid;
        response.result <= resultWord;
        response.flags  <= resultFlags;
    end

    //Invalid and overflow come from disjoint paths
    roundFlagsExclusive: assert property (@(posedge clock) disable iff (reset)
        response.valid |-> !(response.flags.invalid && response.flags.overflow));

endmodule

/* source/fpMantissaAdd.sv */
//FP adder stage 3 that adds or subtracts the aligned mantissas
`timescale 1ns/1ps
`include "fpAdder_defines.svh"

module fpMantissaAdd
(
    input  logic                   clock,
    input  logic                   reset,
    input  fpAdderPkg::fpAligned_t aligned,
    output fpAdderPkg::fpSum_t     sum
);

    logic [`FP_MAN_WIDTH+4:0] total;
    logic                     sumSign;

    //Ordering keeps the difference non-negative
    always_comb
    begin
        if (aligned.effSub)
            total = {1'b0, aligned.bigMant} - {1'b0, aligned.smallMant};
        else
            total = {1'b0, aligned.bigMant} + {1'b0, aligned.smallMant};
    end

    //Exact cancellation yields +0 under round to nearest
    assign sumSign = (aligned.effSub && total == '0) ? 1'b0 : aligned.resultSign;

    always_ff @(posedge clock)
    begin
        if (reset)
            sum.valid <= 1'b0;
        else
            sum.valid <= aligned.valid;
        sum.sign         <= sumSign;
        sum.exponent     <= aligned.exponent;
        sum.sum          <= total;
        sum.special      <= aligned.special;
        sum.specialWord  <= aligned.specialWord;
        sum.specialFlags <= aligned.specialFlags;
    end

endmodule

/* source/fpAlign.sv */
//FP adder stage 2 that detects special cases, orders operands and aligns exponents
`timescale 1ns/1ps
`include "fpAdder_defines.svh"

module fpAlign
(
    input  logic                    clock,
    input  logic                    reset,
    input  fpAdderPkg::fpUnpacked_t unpacked,
    output fpAdderPkg::fpAligned_t  aligned
);

    logic                         aNaN, bNaN, aInf, bInf, aZero, bZero;
    logic                         aNormal, bNormal, swapOps, bigSign;
    logic [`FP_EXP_WIDTH-1:0]     expA, expB, bigExp, smallExp, expDiff;
    logic [`FP_MAN_WIDTH:0]       manA, manB, bigMan, smallMan;
    logic [4:0]                   shiftAmt;
    logic [2*`FP_MAN_WIDTH+7:0]   shiftWide;
    logic [`FP_MAN_WIDTH+3:0]     smallAligned;
    logic                         special;
    logic [`FP_WIDTH-1:0]         specialWord;
    fpAdderPkg::fpFlags_t         specialFlags;

    assign aNaN    = (unpacked.a.fpClass == fpAdderPkg::classNaN);
    assign bNaN    = (unpacked.b.fpClass == fpAdderPkg::classNaN);
    assign aInf    = (unpacked.a.fpClass == fpAdderPkg::classInf);
    assign bInf    = (unpacked.b.fpClass == fpAdderPkg::classInf);
    assign aZero   = (unpacked.a.fpClass == fpAdderPkg::classZero);
    assign bZero   = (unpacked.b.fpClass == fpAdderPkg::classZero);
    assign aNormal = (unpacked.a.fpClass == fpAdderPkg::classNormal);
    assign bNormal = (unpacked.b.fpClass == fpAdderPkg::classNormal);

    //Special results bypass the datapath
    always_comb
    begin
        special      = 1'b1;
        specialWord  = `FP_QNAN;
        specialFlags = '0;
        if (aNaN || bNaN || (aInf && bInf && (unpacked.a.sign != unpacked.b.sign)))
            specialFlags.invalid = 1'b1;
        else if (aInf)
            specialWord = {unpacked.a.sign, {`FP_EXP_WIDTH{1'b1}}, {`FP_MAN_WIDTH{1'b0}}};
        else if (bInf)
            specialWord = {unpacked.b.sign, {`FP_EXP_WIDTH{1'b1}}, {`FP_MAN_WIDTH{1'b0}}};
        else if (aZero && bZero)
            specialWord = {unpacked.a.sign & unpacked.b.sign, {(`FP_WIDTH-1){1'b0}}};
        else
            special = 1'b0;
    end

    //Subnormals get hidden bit 0 and exponent 1
    assign manA = {aNormal, unpacked.a.mantissa};
    assign manB = {bNormal, unpacked.b.mantissa};
    assign expA = aNormal ? unpacked.a.exponent : `FP_EXP_WIDTH'(1);
    assign expB = bNormal ? unpacked.b.exponent : `FP_EXP_WIDTH'(1);

    //Larger magnitude goes first
    assign swapOps  = {expB, manB} > {expA, manA};
    assign bigExp   = swapOps ? expB : expA;
    assign smallExp = swapOps ? expA : expB;
    assign bigMan   = swapOps ? manB : manA;
    assign smallMan = swapOps ? manA : manB;
    assign bigSign  = swapOps ? unpacked.b.sign : unpacked.a.sign;

    //Shift capped at the full mantissa width with lost bits folded into sticky
    assign expDiff      = bigExp - smallExp;
    assign shiftAmt     = (expDiff > `FP_MAN_WIDTH + 4) ? 5'(`FP_MAN_WIDTH + 4) : expDiff[4:0];
    assign shiftWide    = {smallMan, 3'b000, {(`FP_MAN_WIDTH+4){1'b0}}} >> shiftAmt;
    assign smallAligned = {shiftWide[2*`FP_MAN_WIDTH+7:`FP_MAN_WIDTH+5],
                           shiftWide[`FP_MAN_WIDTH+4] | (|shiftWide[`FP_MAN_WIDTH+3:0])};

    always_ff @(posedge clock)
    begin
        if (reset)
            aligned.valid <= 1'b0;
        else
            aligned.valid <= unpacked.valid;
        aligned.resultSign   <= bigSign;
        aligned.exponent     <= bigExp;
        aligned.bigMant      <= special ? '0 : {bigMan, 3'b000};
        aligned.smallMant    <= special ? '0 : smallAligned;
        aligned.effSub       <= unpacked.a.sign ^ unpacked.b.sign;
        aligned.special      <= special;
        aligned.specialWord  <= specialWord;
        aligned.specialFlags <= specialFlags;
    end

    //Ordering and alignment keep the next stage's difference non-negative
    alignOrdered: assert property (@(posedge clock) disable iff (reset)
        aligned.valid && !aligned.special |-> aligned.bigMant >= aligned.smallMant);

endmodule

/* source/fpUnpack.sv */
//FP adder stage 1 that splits both operands into fields and classifies them
`timescale 1ns/1ps
`include "fpAdder_defines.svh"

module fpUnpack
(
    input  logic                    clock,
    input  logic                    reset,
    input  fpAdderPkg::fpRequest_t  request,
    output fpAdderPkg::fpUnpacked_t unpacked
);

    fpAdderPkg::fpOperand_t operandA;
    fpAdderPkg::fpOperand_t operandB;
    logic                   flipB;

    //Field split and class for one word
    function automatic fpAdderPkg::fpOperand_t unpackWord(
        input logic [`FP_WIDTH-1:0] word,
        input logic                 invertSign
    );
        fpAdderPkg::fpOperand_t operand;
        operand.sign     = word[`FP_WIDTH-1] ^ invertSign;
        operand.exponent = word[`FP_WIDTH-2 -: `FP_EXP_WIDTH];
        operand.mantissa = word[`FP_MAN_WIDTH-1:0];
        if (operand.exponent == '0)
            operand.fpClass = (operand.mantissa == '0) ? fpAdderPkg::classZero
                                                       : fpAdderPkg::classSub;
        else if (operand.exponent == `FP_EXP_MAX)
            operand.fpClass = (operand.mantissa == '0) ? fpAdderPkg::classInf
                                                       : fpAdderPkg::classNaN;
        else
            operand.fpClass = fpAdderPkg::classNormal;
        return operand;
    endfunction

    //Subtraction becomes addition of a negated B
    assign flipB    = (request.op == fpAdderPkg::opSub);
    assign operandA = unpackWord(request.a, 1'b0);
    assign operandB = unpackWord(request.b, flipB);

    always_ff @(posedge clock)
    begin
        if (reset)
            unpacked.valid <= 1'b0;
        else
            unpacked.valid <= request.valid;
        unpacked.a <= operandA;
        unpacked.b <= operandB;
    end

    //Stage latency of exactly one cycle once out of reset
    unpackLatency: assert property (@(posedge clock) disable iff (reset)
        !$past(reset) |-> unpacked.valid == $past(request.valid));

endmodule

/* source/fpAdderPkg.sv */
//Operation and class enums and stage structs shared by the FP adder stages
`include "fpAdder_defines.svh"

package fpAdderPkg;

    typedef enum logic {
        opAdd = 1'b0,
        opSub = 1'b1
    } fpOp_e;

    typedef enum logic [2:0] {
        classZero   = 3'd0,
        classSub    = 3'd1,
        classNormal = 3'd2,
        classInf    = 3'd3,
        classNaN    = 3'd4
    } fpClass_e;

    //Top-level request with a one-cycle valid strobe
    typedef struct packed {
        logic                 valid;
        fpOp_e                op;
        logic [`FP_WIDTH-1:0] a;
        logic [`FP_WIDTH-1:0] b;
    } fpRequest_t;

    typedef struct packed {
        logic                     sign;
        logic [`FP_EXP_WIDTH-1:0] exponent;
        logic [`FP_MAN_WIDTH-1:0] mantissa;
        fpClass_e                 fpClass;
    } fpOperand_t;

    typedef struct packed {
        logic invalid;
        logic overflow;
        logic inexact;
    } fpFlags_t;

    //B sign already flipped for subtraction
    typedef struct packed {
        logic       valid;
        fpOperand_t a;
        fpOperand_t b;
    } fpUnpacked_t;

    //Mantissas are hidden bit, fraction, guard, round, sticky
    typedef struct packed {
        logic                     valid;
        logic                     resultSign;
        logic [`FP_EXP_WIDTH-1:0] exponent;
        logic [`FP_MAN_WIDTH+3:0] bigMant;
        logic [`FP_MAN_WIDTH+3:0] smallMant;
        logic                     effSub;
        logic                     special;
        logic [`FP_WIDTH-1:0]     specialWord;
        fpFlags_t                 specialFlags;
    } fpAligned_t;

    typedef struct packed {
        logic                     valid;
        logic                     sign;
        logic [`FP_EXP_WIDTH-1:0] exponent;
        logic [`FP_MAN_WIDTH+4:0] sum;
        logic                     special;
        logic [`FP_WIDTH-1:0]     specialWord;
        fpFlags_t                 specialFlags;
    } fpSum_t;

    typedef struct packed {
        logic                 valid;
        logic [`FP_WIDTH-1:0] result;
        fpFlags_t             flags;
    } fpResult_t;

endpackage

/* source/fpAdder_defines.svh */
//Single-precision format constants shared by the FP adder pipeline
`ifndef FPADDER_DEFINES_SVH
`define FPADDER_DEFINES_SVH

//Word and field widths
`define FP_WIDTH     32
`define FP_EXP_WIDTH 8
`define FP_MAN_WIDTH 23

//Exponent bias and the all-ones exponent reserved for inf and NaN
`define FP_BIAS      127
`define FP_EXP_MAX   (2 * `FP_BIAS + 1)

//Canonical quiet NaN returned for every invalid operation
`define FP_QNAN      32'h7FC0_0000

`endif
